// ==== cpu_top.f ====
+incdir+design
design/cpu_pkg.sv
design/cpu_phase_ctrl.sv
design/cpu_regfile.sv
design/cpu_decode.sv
design/cpu_execute.sv
design/cpu_result.sv
design/cpu_top.sv
verif/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the testbench, then judge the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module cpu_tb -f cpu_top.f -o cpu_tb_sim \
	> build.log 2>&1 \
	&& ./obj_dir/cpu_tb_sim > sim.log 2>&1 \
	|| echo "build or simulation returned an error"
cat build.log
[ -f sim.log ] && cat sim.log
grep -q "Regression passed" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_tb;

	localparam logic [1:0] k_none  = 2'd0;
	localparam logic [1:0] k_load  = 2'd1;
	localparam logic [1:0] k_store = 2'd2;
	localparam int dm_words = 1 << (`CPU_DM_AW - 2);
	localparam int im_words = 1 << `CPU_PC_W;
	localparam logic [`CPU_PC_W-1:0] last_row = 10'd30;
	// word indexes of byte addresses 0x240 and 0x200
	localparam logic [`CPU_DM_AW-3:0] load_idx = 10'h090;
	localparam logic [`CPU_DM_AW-3:0] max_idx  = 10'h080;

	// one program row with its expected results
	typedef struct packed {
		logic [`CPU_XLEN-1:0]  word;
		logic [1:0]            kind;
		logic [`CPU_DM_AW-1:0] addr;
		logic [`CPU_XLEN-1:0]  data;
		logic                  ovf;
		logic [`CPU_PC_W-1:0]  next_pc;
	} row_t;

	logic                  enable_memaccess;
	logic                  rst;
	logic [`CPU_XLEN-1:0]  instruction;
	logic                  alu_overflow;
	logic                  im_read;
	logic                  im_enable;
	logic [`CPU_PC_W-1:0]  im_address;
	logic                  dm_enable;
	logic                  dm_read;
	logic                  dm_write;
	logic [`CPU_DM_AW-1:0] dm_address;
	logic [`CPU_XLEN-1:0]  dm_in;
	logic [`CPU_XLEN-1:0]  dm_out;

	logic [`CPU_XLEN-1:0] dmem [0:dm_words-1];
	row_t                 prog [0:im_words-1];
	string                row_name [0:im_words-1];

	cpu_top dut_i (
		.enable_memaccess (enable_memaccess),
		.rst              (rst),
		.instruction      (instruction),
		.alu_overflow     (alu_overflow),
		.im_read          (im_read),
		.im_enable        (im_enable),
		.im_address       (im_address),
		.dm_enable        (dm_enable),
		.dm_read          (dm_read),
		.dm_write         (dm_write),
		.dm_address       (dm_address),
		.dm_in            (dm_in),
		.dm_out           (dm_out)
	);

	initial enable_memaccess = 1'b0;
	always #4 enable_memaccess = ~enable_memaccess;

	// data memory answers 1 ns into memaccess
	initial begin
		dm_out = '0;
		void'($urandom(32'hc8c0));
		for (int i = 0; i < dm_words; i++) begin
			dmem[i] = $urandom;
		end
		// largest positive word for the overflow case
		dmem[max_idx] = 32'h7fff_ffff;
		forever begin
			@(posedge enable_memaccess);
			#1;
			if (dm_write)
				dmem[dm_address[`CPU_DM_AW-1:2]] = dm_in;
			dm_out = dm_read ? dmem[dm_address[`CPU_DM_AW-1:2]] : '0;
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [`CPU_XLEN-1:0] exp,
		input logic [`CPU_XLEN-1:0] act);
		if (act !== exp)
			abort_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_addr(input string name, input logic [`CPU_DM_AW-1:0] exp,
		input logic [`CPU_DM_AW-1:0] act);
		if (act !== exp)
			abort_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
	endtask

	// polls 1 ns after each edge
	task automatic wait_strobe(input string which);
		int n;
		logic seen;
		n = 0;
		seen = (which == "im_enable") ? im_enable : dm_enable;
		while (!seen) begin
			if (n == 20) begin
				abort_run({which, " never came within 20 cycles"});
			end else begin
				@(posedge enable_memaccess);
				#1;
				n++;
				seen = (which == "im_enable") ? im_enable : dm_enable;
			end
		end
	endtask

	function automatic logic [31:0] enc_alu(input logic [4:0] sub, input int rt, input int ra,
		input int rb);
		return {1'b0, `OP_ALU, rt[4:0], ra[4:0], rb[4:0], 5'b00000, sub};
	endfunction

	function automatic logic [31:0] enc_mem(input logic [5:0] op, input int rt, input int ra,
		input int imm);
		return {1'b0, op, rt[4:0], ra[4:0], imm[14:0]};
	endfunction

	function automatic logic [31:0] enc_movi(input int rt, input int imm);
		return {1'b0, `OP_MOVI, rt[4:0], imm[19:0]};
	endfunction

	// beq compares rt with ra
	function automatic logic [31:0] enc_beq(input int rt, input int ra, input int off);
		return {1'b0, `OP_BEQ, rt[4:0], ra[4:0], 1'b0, off[13:0]};
	endfunction

	task automatic put_row(input logic [`CPU_PC_W-1:0] idx, input string name,
		input logic [31:0] word, input logic [1:0] kind, input logic [`CPU_DM_AW-1:0] addr,
		input logic [31:0] data, input logic ovf);
		prog[idx] = '{word, kind, addr, data, ovf, idx + 1'b1};
		row_name[idx] = name;
	endtask

	task automatic build_program();
		logic [31:0] va;
		logic [31:0] vb;
		logic [31:0] ld;
		va = 32'h0001_2345;
		vb = -32'sd1000;
		ld = dmem[load_idx];
		put_row(0, "movi pos", enc_movi(1, 'h12345), k_none, 12'h000, 32'h0, 1'b0);
		put_row(1, "movi neg", enc_movi(2, -1000), k_none, 12'h000, 32'h0, 1'b0);
		put_row(2, "add", enc_alu(`SUB_ADD, 3, 1, 2), k_none, 12'h000, 32'h0, 1'b0);
		put_row(3, "swi add", enc_mem(`OP_SWI, 3, 0, 'h100), k_store, 12'h100, va + vb, 1'b0);
		put_row(4, "sub", enc_alu(`SUB_SUB, 4, 1, 2), k_none, 12'h000, 32'h0, 1'b0);
		put_row(5, "swi sub", enc_mem(`OP_SWI, 4, 0, 'h104), k_store, 12'h104, va - vb, 1'b0);
		put_row(6, "and", enc_alu(`SUB_AND, 5, 1, 2), k_none, 12'h000, 32'h0, 1'b0);
		put_row(7, "swi and", enc_mem(`OP_SWI, 5, 0, 'h108), k_store, 12'h108, va & vb, 1'b0);
		put_row(8, "or", enc_alu(`SUB_OR, 6, 1, 2), k_none, 12'h000, 32'h0, 1'b0);
		put_row(9, "swi or", enc_mem(`OP_SWI, 6, 0, 'h10c), k_store, 12'h10c, va | vb, 1'b0);
		put_row(10, "xor", enc_alu(`SUB_XOR, 7, 1, 2), k_none, 12'h000, 32'h0, 1'b0);
		put_row(11, "swi xor", enc_mem(`OP_SWI, 7, 0, 'h110), k_store, 12'h110, va ^ vb, 1'b0);
		put_row(12, "slt true", enc_alu(`SUB_SLT, 8, 2, 1), k_none, 12'h000, 32'h0, 1'b0);
		put_row(13, "swi slt true", enc_mem(`OP_SWI, 8, 0, 'h114), k_store, 12'h114,
			($signed(vb) < $signed(va)) ? 32'd1 : 32'd0, 1'b0);
		put_row(14, "slt false", enc_alu(`SUB_SLT, 9, 1, 2), k_none, 12'h000, 32'h0, 1'b0);
		put_row(15, "swi slt false", enc_mem(`OP_SWI, 9, 0, 'h118), k_store, 12'h118,
			($signed(va) < $signed(vb)) ? 32'd1 : 32'd0, 1'b0);
		put_row(16, "addi neg", enc_mem(`OP_ADDI, 10, 1, -300), k_none, 12'h000, 32'h0, 1'b0);
		put_row(17, "swi addi", enc_mem(`OP_SWI, 10, 0, 'h11c), k_store, 12'h11c,
			va - 32'd300, 1'b0);
		put_row(18, "movi base", enc_movi(11, 'h200), k_none, 12'h000, 32'h0, 1'b0);
		put_row(19, "lwi random", enc_mem(`OP_LWI, 12, 11, 'h40), k_load, 12'h240, 32'h0, 1'b0);
		put_row(20, "swi round trip", enc_mem(`OP_SWI, 12, 11, -4), k_store, 12'h1fc, ld, 1'b0);
		put_row(21, "lwi max", enc_mem(`OP_LWI, 13, 11, 0), k_load, 12'h200, 32'h0, 1'b0);
		put_row(22, "movi one", enc_movi(14, 1), k_none, 12'h000, 32'h0, 1'b0);
		put_row(23, "add overflow", enc_alu(`SUB_ADD, 15, 13, 14), k_none, 12'h000, 32'h0, 1'b1);
		put_row(24, "and clears", enc_alu(`SUB_AND, 16, 13, 14), k_none, 12'h000, 32'h0, 1'b0);
		put_row(25, "swi wrapped", enc_mem(`OP_SWI, 15, 0, 'h120), k_store, 12'h120,
			32'h7fff_ffff + 32'd1, 1'b0);
		put_row(26, "beq taken", enc_beq(1, 1, 3), k_none, 12'h000, 32'h0, 1'b0);
		prog[26].next_pc = 10'd26 + 10'd3;
		// skipped by the taken branch
		put_row(27, "skipped a", enc_mem(`OP_SWI, 1, 0, 'h300), k_store, 12'h300, va, 1'b0);
		put_row(28, "skipped b", enc_mem(`OP_SWI, 2, 0, 'h304), k_store, 12'h304, vb, 1'b0);
		put_row(29, "beq not taken", enc_beq(2, 1, 5), k_none, 12'h000, 32'h0, 1'b0);
		put_row(30, "swi and result", enc_mem(`OP_SWI, 16, 0, 'h124), k_store, 12'h124,
			32'h7fff_ffff & 32'd1, 1'b0);
	endtask

	initial begin
		row_t row;
		logic [`CPU_PC_W-1:0] pc_exp;
		logic [`CPU_PC_W-1:0] cur;
		logic done;
		rst = 1'b1;
		instruction = '0;
		for (int i = 0; i < 8; i++) begin
			@(posedge enable_memaccess);
			#1;
			check_flag("reset dm_write", 1'b0, dm_write);
			check_flag("reset overflow", 1'b0, alu_overflow);
		end
		rst = 1'b0;
		build_program();
		pc_exp = '0;
		done = 1'b0;
		while (!done) begin
			wait_strobe("im_enable");
			check_addr("fetch address", `CPU_DM_AW'(pc_exp), `CPU_DM_AW'(im_address));
			check_flag("fetch im_read", 1'b1, im_read);
			cur = im_address;
			row = prog[cur];
			instruction = row.word;
			wait_strobe("dm_enable");
			check_flag({row_name[cur], " im_read"}, 1'b0, im_read);
			check_flag({row_name[cur], " overflow"}, row.ovf, alu_overflow);
			check_flag({row_name[cur], " dm_write"}, row.kind == k_store, dm_write);
			check_flag({row_name[cur], " dm_read"}, row.kind == k_load, dm_read);
			if (row.kind != k_none)
				check_addr({row_name[cur], " dm_address"}, row.addr, dm_address);
			if (row.kind == k_store)
				check_word({row_name[cur], " dm_in"}, row.data, dm_in);
			pc_exp = row.next_pc;
			done = (cur == last_row);
		end
		// next fetch address after the last row
		wait_strobe("im_enable");
		check_addr("final fetch", `CPU_DM_AW'(pc_exp), `CPU_DM_AW'(im_address));
		$display("Regression passed");
		$finish;
	end

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_top import cpu_pkg::*; (
	input  logic                  enable_memaccess,
	input  logic                  rst,
	input  logic [`CPU_XLEN-1:0]  instruction,
	output logic                  alu_overflow,
	output logic                  im_read,
	output logic                  im_enable,
	output logic [`CPU_PC_W-1:0]  im_address,
	output logic                  dm_enable,
	output logic                  dm_read,
	output logic                  dm_write,
	output logic [`CPU_DM_AW-1:0] dm_address,
	output logic [`CPU_XLEN-1:0]  dm_in,
	input  logic [`CPU_XLEN-1:0]  dm_out
);

	phase_e               phase;
	logic [`CPU_PC_W-1:0] pc;
	logic                 take_branch;
	logic [4:0]           ra_addr;
	logic [4:0]           rb_addr;
	logic [4:0]           rt_addr;
	logic [`CPU_XLEN-1:0] ra_data;
	logic [`CPU_XLEN-1:0] rb_data;
	logic [`CPU_XLEN-1:0] rt_data;
	logic                 reg_we;
	logic [`CPU_XLEN-1:0] reg_wdata;
	decoded_t             dec;
	exec_t                ex;
	logic [`CPU_XLEN-1:0] src_a;
	logic [`CPU_XLEN-1:0] src_b;
	logic [`CPU_XLEN-1:0] store_val;

	// instruction fetch is a plain read during the fetch phase
	assign im_enable  = (phase == ph_fetch);
	assign im_read    = im_enable;
	assign im_address = pc;

	cpu_phase_ctrl phase_ctrl_i (
		.enable_memaccess (enable_memaccess),
		.rst              (rst),
		.take_branch      (take_branch),
		.branch_off       (dec.branch_off),
		.phase            (phase),
		.pc               (pc)
	);

	cpu_regfile regfile_i (
		.enable_memaccess (enable_memaccess),
		.rst              (rst),
		.ra_addr          (ra_addr),
		.rb_addr          (rb_addr),
		.rt_addr          (rt_addr),
		.we               (reg_we),
		.wdata            (reg_wdata),
		.ra_data          (ra_data),
		.rb_data          (rb_data),
		.rt_data          (rt_data)
	);

	cpu_decode decode_i (
		.enable_memaccess (enable_memaccess),
		.rst              (rst),
		.phase            (phase),
		.instruction      (instruction),
		.ra_addr          (ra_addr),
		.rb_addr          (rb_addr),
		.rt_addr          (rt_addr),
		.ra_data          (ra_data),
		.rb_data          (rb_data),
		.rt_data          (rt_data),
		.dec              (dec),
		.src_a            (src_a),
		.src_b            (src_b),
		.store_val        (store_val)
	);

	cpu_execute execute_i (
		.enable_memaccess (enable_memaccess),
		.rst              (rst),
		.phase            (phase),
		.dec              (dec),
		.src_a            (src_a),
		.src_b            (src_b),
		.store_val        (store_val),
		.ex               (ex),
		.take_branch      (take_branch),
		.alu_overflow     (alu_overflow)
	);

	cpu_result result_i (
		.enable_memaccess (enable_memaccess),
		.rst              (rst),
		.phase            (phase),
		.dec              (dec),
		.ex               (ex),
		.dm_enable        (dm_enable),
		.dm_read          (dm_read),
		.dm_write         (dm_write),
		.dm_address       (dm_address),
		.dm_in            (dm_in),
		.dm_out           (dm_out),
		.reg_we           (reg_we),
		.reg_wdata        (reg_wdata)
	);

endmodule

// ==== design/cpu_result.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_result import cpu_pkg::*; (
	input  logic                  enable_memaccess,
	input  logic                  rst,
	input  phase_e                phase,
	input  decoded_t              dec,
	input  exec_t                 ex,
	output logic                  dm_enable,
	output logic                  dm_read,
	output logic                  dm_write,
	output logic [`CPU_DM_AW-1:0] dm_address,
	output logic [`CPU_XLEN-1:0]  dm_in,
	input  logic [`CPU_XLEN-1:0]  dm_out,
	output logic                  reg_we,
	output logic [`CPU_XLEN-1:0]  reg_wdata
);

	logic [`CPU_XLEN-1:0] load_q;

	assign dm_enable  = (phase == ph_memaccess);
	assign dm_read    = dm_enable && dec.mem_read;
	assign dm_write   = dm_enable && dec.mem_write;
	assign dm_address = ex.result[`CPU_DM_AW-1:0];
	assign dm_in      = ex.store_data;

	// memory answers within memaccess
	always_ff @(posedge enable_memaccess) begin
		if (dm_read)
			load_q <= dm_out;
	end

	assign reg_we    = (phase == ph_writeback) && dec.reg_write;
	assign reg_wdata = dec.mem_read ? load_q : ex.result;

	// a store only happens in memaccess, and writeback follows it
	a_store_in_memaccess: assert property (
		@(posedge enable_memaccess) disable iff (rst)
		dm_write |-> phase == ph_memaccess ##1 phase == ph_writeback
	);

endmodule

// ==== design/cpu_execute.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_execute import cpu_pkg::*; (
	input  logic                 enable_memaccess,
	input  logic                 rst,
	input  phase_e               phase,
	input  decoded_t             dec,
	input  logic [`CPU_XLEN-1:0] src_a,
	input  logic [`CPU_XLEN-1:0] src_b,
	input  logic [`CPU_XLEN-1:0] store_val,
	output exec_t                ex,
	output logic                 take_branch,
	output logic                 alu_overflow
);

	logic [`CPU_XLEN-1:0] sum;
	logic [`CPU_XLEN-1:0] diff;
	logic [`CPU_XLEN-1:0] alu_res;
	logic                 ovf;
	logic                 arith;

	assign sum  = src_a + src_b;
	assign diff = src_a - src_b;

	always_comb begin
		case (dec.alu_op)
			alu_add:    alu_res = sum;
			alu_sub:    alu_res = diff;
			alu_and:    alu_res = src_a & src_b;
			alu_or:     alu_res = src_a | src_b;
			alu_xor:    alu_res = src_a ^ src_b;
			alu_slt:    alu_res = {{(`CPU_XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
			default:    alu_res = src_b;
		endcase
	end

	// address adds of lwi/swi never flag overflow
	assign arith = !dec.mem_read && !dec.mem_write;

	always_comb begin
		ovf = 1'b0;
		if (arith && dec.alu_op == alu_add)
			ovf = (src_a[`CPU_XLEN-1] == src_b[`CPU_XLEN-1]) &&
				(sum[`CPU_XLEN-1] != src_a[`CPU_XLEN-1]);
		else if (arith && dec.alu_op == alu_sub)
			ovf = (src_a[`CPU_XLEN-1] != src_b[`CPU_XLEN-1]) &&
				(diff[`CPU_XLEN-1] != src_a[`CPU_XLEN-1]);
	end

	always_ff @(posedge enable_memaccess) begin
		if (rst) begin
			ex <= '0;
		end else if (phase == ph_execute) begin
			ex.result     <= alu_res;
			ex.store_data <= store_val;
			ex.overflow   <= ovf;
		end
	end

	// flag held until the next execute
	assign alu_overflow = ex.overflow;

	assign take_branch = (phase == ph_execute) && dec.is_branch && (src_a == src_b);

endmodule

// ==== design/cpu_decode.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_decode import cpu_pkg::*; (
	input  logic                 enable_memaccess,
	input  logic                 rst,
	input  phase_e               phase,
	input  logic [`CPU_XLEN-1:0] instruction,
	output logic [4:0]           ra_addr,
	output logic [4:0]           rb_addr,
	output logic [4:0]           rt_addr,
	input  logic [`CPU_XLEN-1:0] ra_data,
	input  logic [`CPU_XLEN-1:0] rb_data,
	input  logic [`CPU_XLEN-1:0] rt_data,
	output decoded_t             dec,
	output logic [`CPU_XLEN-1:0] src_a,
	output logic [`CPU_XLEN-1:0] src_b,
	output logic [`CPU_XLEN-1:0] store_val
);

	logic [`CPU_XLEN-1:0] instr_q;
	logic [5:0]           opcode;
	logic [4:0]           sub_op;
	logic                 is_alu;
	decoded_t             dec_d;
	logic [`CPU_XLEN-1:0] src_b_d;

	always_ff @(posedge enable_memaccess) begin
		if (phase == ph_fetch)
			instr_q <= instruction;
	end

	assign opcode  = instr_q[30:25];
	assign sub_op  = instr_q[4:0];
	assign ra_addr = instr_q[19:15];
	assign rb_addr = instr_q[14:10];
	assign rt_addr = instr_q[24:20];
	assign is_alu  = (opcode == `OP_ALU);

	always_comb begin
		dec_d            = '0;
		dec_d.alu_op     = alu_pass_b;
		dec_d.rt         = instr_q[24:20];
		dec_d.branch_off = instr_q[13:0];
		case (opcode)
			`OP_ALU: begin
				dec_d.reg_write = 1'b1;
				case (sub_op)
					`SUB_ADD: dec_d.alu_op = alu_add;
					`SUB_SUB: dec_d.alu_op = alu_sub;
					`SUB_AND: dec_d.alu_op = alu_and;
					`SUB_OR:  dec_d.alu_op = alu_or;
					`SUB_XOR: dec_d.alu_op = alu_xor;
					`SUB_SLT: dec_d.alu_op = alu_slt;
					default:  dec_d.reg_write = 1'b0;
				endcase
			end
			`OP_ADDI, `OP_LWI, `OP_SWI: begin
				dec_d.alu_op    = alu_add;
				dec_d.use_imm   = 1'b1;
				dec_d.imm       = {{(`CPU_XLEN-15){instr_q[14]}}, instr_q[14:0]};
				dec_d.mem_read  = (opcode == `OP_LWI);
				dec_d.mem_write = (opcode == `OP_SWI);
				dec_d.reg_write = (opcode != `OP_SWI);
			end
			`OP_MOVI: begin
				dec_d.use_imm   = 1'b1;
				dec_d.imm       = {{(`CPU_XLEN-20){instr_q[19]}}, instr_q[19:0]};
				dec_d.reg_write = 1'b1;
			end
			`OP_BEQ: dec_d.is_branch = 1'b1;
			default: ;
		endcase
	end

	// beq compares rt against ra
	always_comb begin
		if (dec_d.is_branch)
			src_b_d = rt_data;
		else if (dec_d.use_imm || !is_alu)
			src_b_d = dec_d.imm;
		else
			src_b_d = rb_data;
	end

	always_ff @(posedge enable_memaccess) begin
		if (rst)
			dec <= '0;
		else if (phase == ph_decode)
			dec <= dec_d;
	end

	always_ff @(posedge enable_memaccess) begin
		if (phase == ph_decode) begin
			src_a     <= ra_data;
			src_b     <= src_b_d;
			store_val <= rt_data;
		end
	end

	a_no_rd_wr: assert property (
		@(posedge enable_memaccess) disable iff (rst)
		!(dec.mem_read && dec.mem_write)
	);

endmodule

// ==== design/cpu_regfile.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_regfile (
	input  logic                 enable_memaccess,
	input  logic                 rst,
	input  logic [4:0]           ra_addr,
	input  logic [4:0]           rb_addr,
	input  logic [4:0]           rt_addr,
	input  logic                 we,
	input  logic [`CPU_XLEN-1:0] wdata,
	output logic [`CPU_XLEN-1:0] ra_data,
	output logic [`CPU_XLEN-1:0] rb_data,
	output logic [`CPU_XLEN-1:0] rt_data
);

	logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

	always_ff @(posedge enable_memaccess) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[rt_addr] <= wdata;
		end
	end

	// three async read ports
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];

endmodule

// ==== design/cpu_phase_ctrl.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_phase_ctrl import cpu_pkg::*; (
	input  logic                  enable_memaccess,
	input  logic                  rst,
	input  logic                  take_branch,
	input  logic signed [13:0]    branch_off,
	output phase_e                phase,
	output logic [`CPU_PC_W-1:0]  pc
);

	always_ff @(posedge enable_memaccess) begin
		if (rst) begin
			phase <= ph_fetch;
		end else begin
			// writeback wraps back to fetch
			phase <= phase_e'({phase[3:0], phase[4]});
		end
	end

	// pc moves once per instruction, at the end of execute
	always_ff @(posedge enable_memaccess) begin
		if (rst) begin
			pc <= '0;
		end else if (phase == ph_execute) begin
			if (take_branch)
				pc <= pc + branch_off[`CPU_PC_W-1:0];
			else
				pc <= pc + 1'b1;
		end
	end

	a_phase_onehot: assert property (
		@(posedge enable_memaccess) disable iff (rst)
		$onehot(phase) ##1 $onehot(phase)
	);

endmodule

// ==== design/cpu_pkg.sv ====
`include "cpu_macros.svh"

package cpu_pkg;

	// one-hot phase strobes, rotated every cycle
	typedef enum logic [4:0] {
		ph_fetch     = 5'b00001,
		ph_decode    = 5'b00010,
		ph_execute   = 5'b00100,
		ph_memaccess = 5'b01000,
		ph_writeback = 5'b10000
	} phase_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_pass_b
	} alu_op_e;

	// control bundle from decode to execute and result
	typedef struct packed {
		alu_op_e                 alu_op;
		logic [4:0]              rt;
		logic                    use_imm;
		logic [`CPU_XLEN-1:0]    imm;
		logic                    mem_read;
		logic                    mem_write;
		logic                    reg_write;
		logic                    is_branch;
		logic signed [13:0]      branch_off;
	} decoded_t;

	// registered execute result
	typedef struct packed {
		logic [`CPU_XLEN-1:0] result;
		logic [`CPU_XLEN-1:0] store_data;
		logic                 overflow;
	} exec_t;

endpackage

// ==== design/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define CPU_XLEN	32
`define CPU_PC_W	10
`define CPU_DM_AW	12
`define CPU_NREGS	32

// opcode field, instruction bits 30:25
`define OP_ALU		6'b100000
`define OP_ADDI		6'b101000
`define OP_MOVI		6'b100010
`define OP_LWI		6'b000010
`define OP_SWI		6'b001010
`define OP_BEQ		6'b100110

// sub-op field of OP_ALU, bits 4:0
`define SUB_ADD		5'b00000
`define SUB_SUB		5'b00001
`define SUB_AND		5'b00010
`define SUB_XOR		5'b00011
`define SUB_OR		5'b00100
`define SUB_SLT		5'b00110

`endif
